// File: sim.f
+incdir+test
source/pcs_rx_pkg.sv
source/gearbox_rx.sv
source/block_sync_rx.sv
source/descrambler_rx.sv
source/block_decode_rx.sv
source/pcs_rx_lane.sv
source/pcs_rx_top.sv
test/pcs_rx_tb.sv

// File: test/pcs_rx_model.svh
`ifndef PCS_RX_MODEL_SVH
`define PCS_RX_MODEL_SVH

// transmit side of each lane, lives inside the testbench module
logic [57:0]  scr_q  [LANES]; // tx scrambler history, bit 0 newest
logic [131:0] bits_q [LANES]; // serial bits not yet cut, first bit at 0
int           fill   [LANES]; // bits waiting in bits_q
int           blk_n  [LANES]; // blocks built so far
logic [63:0]  exp_data [LANES][MAX_BLK];
logic         exp_ctrl [LANES][MAX_BLK];
logic         exp_err  [LANES][MAX_BLK];

// the fifteen type bytes of clause 49, index 0 in the low byte
localparam logic [15*8-1:0] BT_ALL = {8'hff, 8'he1, 8'hd2, 8'hcc, 8'hb4, 8'haa, 8'h99,
	8'h87, 8'h78, 8'h66, 8'h55, 8'h4b, 8'h33, 8'h2d, 8'h1e};

function automatic bit bt_legal(input logic [7:0] b);
	for (int i = 0; i < 15; i++)
		if (BT_ALL[i*8 +: 8] == b)
			return 1'b1;
	return 1'b0;
endfunction

// expected decoder result for one sent block, {err, ctrl, data}
function automatic logic [65:0] ref_decode(input logic [1:0] head, input payload_u pl);
	logic ctrl;
	logic err;
	ctrl = (head == 2'b10);
	err  = (head == 2'b00) || (head == 2'b11) || (ctrl && !bt_legal(pl.ctrl.btype));
	return {err, ctrl, pl.data}; // payload kept even when flagged
endfunction

// serial scrambler, s = d ^ s(-39) ^ s(-58)
function automatic logic [63:0] scramble(input int l, input logic [63:0] d);
	logic [63:0] s;
	for (int i = 0; i < 64; i++) begin
		s[i]     = d[i] ^ scr_q[l][38] ^ scr_q[l][57];
		scr_q[l] = {scr_q[l][56:0], s[i]};
	end
	return s;
endfunction

// one more block into the lane's bit stream
task automatic add_block(input int l);
	payload_u    pl;
	logic [1:0]  head;
	logic [65:0] res;
	logic [7:0]  bt;
	int          j;
	j       = blk_n[l];
	pl.data = {$random(seed), $random(seed)};
	head    = 2'b01;
	if (($random(seed) & 3) == 0) begin // about one in four is control
		head          = 2'b10;
		pl.ctrl.btype = BT_ALL[($unsigned($random(seed)) % 15) * 8 +: 8];
	end
	if (err_inj && j % 40 == 33) begin
		bt = 8'($random(seed));
		while (bt_legal(bt))
			bt = 8'($random(seed));
		head          = 2'b10;
		pl.ctrl.btype = bt; // unknown type byte
	end
	if ((err_inj && j % 40 == 13) || bad_run[l])
		head = j[0] ? 2'b11 : 2'b00; // both bad codes in turn
	res = ref_decode(head, pl);
	exp_err[l][j]  = res[65];
	exp_ctrl[l][j] = res[64];
	exp_data[l][j] = res[63:0];
	bits_q[l] = bits_q[l] | ({66'd0, scramble(l, pl.data), head} << fill[l]);
	fill[l]   = fill[l] + BLOCK_W;
	blk_n[l]  = j + 1;
endtask

// next 66 bits of every lane onto chunk_i
task automatic cut_chunks();
	for (int l = 0; l < LANES; l++) begin
		while (fill[l] < BLOCK_W)
			add_block(l);
		chunk_i[l*BLOCK_W +: BLOCK_W] = bits_q[l][65:0];
		bits_q[l] = bits_q[l] >> BLOCK_W;
		fill[l]   = fill[l] - BLOCK_W;
	end
endtask

// random scrambler state and random junk bits ahead of block 0
task automatic model_init();
	int          sh;
	logic [63:0] r;
	for (int l = 0; l < LANES; l++) begin
		sh        = $unsigned($random(seed)) % 66;
		r         = {$random(seed), $random(seed)};
		scr_q[l]  = r[57:0];
		r         = {$random(seed), $random(seed)};
		bits_q[l] = {68'd0, r} & ((132'd1 << sh) - 132'd1);
		fill[l]   = sh; // block 0 starts this many bits in
		blk_n[l]  = 0;
		$display("lane %0d: stream shifted by %0d bits", l, sh);
	end
endtask

`endif

// File: test/pcs_rx_tb.sv
`default_nettype none

module pcs_rx_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pcs_rx_pkg::*;

	localparam int LANES   = 4;
	localparam int ACQ_LIM = 66 * 70;            // full offset hunt, cycles
	localparam int RUN_LIM = 3 * ACQ_LIM + 2600; // three hunts plus fixed phases
	localparam int MAX_BLK = RUN_LIM + 8;        // never more than one block per cycle

	logic                       clk = 1'b0;
	logic                       nreset;
	logic [LANES-1:0]           signal_ok_i;
	logic                       valid_i;
	logic [LANES*BLOCK_W-1:0]   chunk_i;
	logic                       valid_o;
	logic [LANES*PAYLOAD_W-1:0] data_o;
	logic [LANES-1:0]           ctrl_o;
	logic [LANES-1:0]           err_o;
	logic [LANES-1:0]           lane_lock_o;
	logic                       all_lock_o;

	integer           seed = 44;
	logic             running;  // stimulus on
	logic             gaps_on;  // random idle cycles
	logic             err_inj;  // periodic bad blocks on all lanes
	logic [LANES-1:0] bad_run;  // every header bad on that lane
	logic [2:0]       vhist;    // valid_i of the last three cycles, [2] oldest
	logic [LANES-1:0] armed;    // lock seen on an earlier output block
	logic             lost;
	int               errors = 0;
	int               cyc = 0;
	int               out_n;    // output blocks since reset, same as chunk number
	int               checked  [LANES];
	int               err_seen [LANES];
	int               n;

	`include "pcs_rx_model.svh"

	pcs_rx_top #(
		.LANES (LANES)
	) i_pcs_rx_top (
		.clk         (clk),
		.nreset      (nreset),
		.signal_ok_i (signal_ok_i),
		.valid_i     (valid_i),
		.chunk_i     (chunk_i),
		.valid_o     (valid_o),
		.data_o      (data_o),
		.ctrl_o      (ctrl_o),
		.err_o       (err_o),
		.lane_lock_o (lane_lock_o),
		.all_lock_o  (all_lock_o)
	);

	always #10 clk = ~clk;

	task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		errors++;
		$display("MISMATCH time %0t %s expected %h actual %h", $time, sig, exp_v, act_v);
	endtask

	task automatic print_summary();
		$display("errors: %0d, blocks compared per lane: %0d %0d %0d %0d", errors,
			checked[0], checked[1], checked[2], checked[3]);
	endtask

	// wait for all lanes, lanes in keep must not drop meanwhile
	task automatic wait_lock(input logic [LANES-1:0] keep, input string what);
		int   k;
		logic broke;
		k     = 0;
		broke = 1'b0;
		while (lane_lock_o !== '1 && k < ACQ_LIM) begin
			@(negedge clk);
			k++;
			if ((lane_lock_o & keep) !== keep && !broke) begin
				errors++;
				broke = 1'b1;
				$display("time %0t: a locked lane lost lock during %s", $time, what);
			end
		end
		if (lane_lock_o !== '1) begin
			errors++;
			$display("lanes %b not locked within %0d cycles in %s", ~lane_lock_o, ACQ_LIM, what);
		end else begin
			$display("time %0t: all lanes locked after %0d cycles in %s", $time, k, what);
			if (all_lock_o !== 1'b1)
				report_mismatch("all_lock_o", 1'b1, all_lock_o); // every lane up
		end
	endtask

	// output j-th block against the sent one, once lock has settled
	task automatic compare_outputs();
		int j;
		if (valid_o !== vhist[2])
			report_mismatch("valid_o", vhist[2], valid_o); // fixed 3 cycle latency
		if (all_lock_o !== &lane_lock_o)
			report_mismatch("all_lock_o", &lane_lock_o, all_lock_o);
		if (valid_o === 1'b1) begin
			j = out_n - 1; // chunk n aligns block n-1 at the right offset
			for (int l = 0; l < LANES; l++) begin
				if (lane_lock_o[l] !== 1'b1)
					armed[l] = 1'b0;
				else if (!armed[l] || j < 0)
					armed[l] = 1'b1; // first block after lock skipped
				else begin
					if (data_o[l*PAYLOAD_W +: PAYLOAD_W] !== exp_data[l][j])
						report_mismatch($sformatf("data_o[%0d]", l), exp_data[l][j],
							data_o[l*PAYLOAD_W +: PAYLOAD_W]);
					if (ctrl_o[l] !== exp_ctrl[l][j])
						report_mismatch($sformatf("ctrl_o[%0d]", l), exp_ctrl[l][j], ctrl_o[l]);
					if (err_o[l] !== exp_err[l][j])
						report_mismatch($sformatf("err_o[%0d]", l), exp_err[l][j], err_o[l]);
					checked[l]++;
					if (exp_err[l][j])
						err_seen[l]++;
				end
			end
			out_n++;
		end
	endtask

	// inputs change 2 ns after the rising edge
	always @(posedge clk) begin
		#2;
		if (running) begin
			valid_i = !gaps_on || ($random(seed) % 4 != 0);
			if (valid_i)
				cut_chunks();
		end else
			valid_i = 1'b0;
	end

	// outputs sampled mid-cycle, run limit kept here too
	always @(negedge clk) begin
		cyc++;
		if (cyc >= RUN_LIM) begin
			errors++;
			$display("timeout: run went past %0d cycles", RUN_LIM);
			print_summary();
			$display("=== FAIL ===");
			$finish;
		end else if (nreset) begin
			vhist = '0;
			armed = '0;
			out_n = 0;
		end else begin
			compare_outputs();
			vhist = {vhist[1:0], valid_i};
		end
	end

	initial begin
		nreset      = 1'b1;
		valid_i     = 1'b0;
		chunk_i     = '0;
		signal_ok_i = '1;
		running     = 1'b0;
		gaps_on     = 1'b0;
		err_inj     = 1'b0;
		bad_run     = '0;
		lost        = 1'b0;
		for (int l = 0; l < LANES; l++) begin
			checked[l]  = 0;
			err_seen[l] = 0;
		end
		model_init();
		repeat (2) @(posedge clk);
		#2 nreset = 1'b0;
		@(negedge clk) running = 1'b1;

		wait_lock('0, "initial acquisition");
		repeat (400) @(negedge clk); // clean payload run

		err_inj = 1'b1; // sparse bad headers and type bytes
		repeat (400) begin
			@(negedge clk);
			if (lane_lock_o !== '1 && !lost) begin
				errors++;
				lost = 1'b1;
				$display("time %0t: isolated bad blocks dropped lock", $time);
			end
		end
		err_inj = 1'b0;

		bad_run[1] = 1'b1; // burst on lane 1 until it lets go
		n = 0;
		while (lane_lock_o[1] === 1'b1 && n < 400) begin
			@(negedge clk);
			n++;
		end
		bad_run[1] = 1'b0;
		if (lane_lock_o[1] !== 1'b0) begin
			errors++;
			$display("lane 1 kept lock through a run of bad headers");
		end
		if (all_lock_o !== 1'b0)
			report_mismatch("all_lock_o", 1'b0, all_lock_o); // one lane down
		if (lane_lock_o[0] !== 1'b1 || lane_lock_o[2] !== 1'b1 || lane_lock_o[3] !== 1'b1) begin
			errors++;
			$display("time %0t: bad headers on lane 1 hit other lanes", $time);
		end
		wait_lock(4'b1101, "lane 1 relock");

		@(posedge clk);
		#2 signal_ok_i[2] = 1'b0; // signal gone on lane 2
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (lane_lock_o[2] !== 1'b0) begin
			errors++;
			$display("lane 2 still locked two blocks after signal loss");
		end
		repeat (10) @(negedge clk);
		if (lane_lock_o[2] !== 1'b0) begin
			errors++;
			$display("lane 2 locked again while its signal was down");
		end
		@(posedge clk);
		#2 signal_ok_i[2] = 1'b1;
		wait_lock(4'b1011, "lane 2 signal recovery");

		@(negedge clk) gaps_on = 1'b1;
		repeat (600) @(negedge clk);
		gaps_on = 1'b0;
		repeat (10) @(negedge clk);
		if (lane_lock_o !== '1) begin
			errors++;
			$display("lock lost during the valid gap run");
		end
		running = 1'b0;
		repeat (6) @(negedge clk); // drain the pipeline

		for (int l = 0; l < LANES; l++) begin
			if (checked[l] < 500) begin
				errors++;
				$display("lane %0d compared only %0d blocks", l, checked[l]);
			end
			if (err_seen[l] == 0) begin
				errors++;
				$display("lane %0d never compared a flagged block", l);
			end
		end
		print_summary();
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/pcs_rx_top.sv
`default_nettype none

// multi-lane receive pcs, lanes run side by side on one strobe
module pcs_rx_top #(
	parameter int LANES = 4
) (
	input  logic                                   clk,
	input  logic                                   nreset,
	input  logic [LANES-1:0]                       signal_ok_i,
	input  logic                                   valid_i,
	input  logic [LANES*pcs_rx_pkg::BLOCK_W-1:0]   chunk_i,
	output logic                                   valid_o,
	output logic [LANES*pcs_rx_pkg::PAYLOAD_W-1:0] data_o,
	output logic [LANES-1:0]                       ctrl_o,
	output logic [LANES-1:0]                       err_o,
	output logic [LANES-1:0]                       lane_lock_o,
	output logic                                   all_lock_o
);
	import pcs_rx_pkg::*;

	logic [LANES-1:0] lane_valid; // per lane strobes, all equal

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		pcs_rx_lane i_pcs_rx_lane (
			.clk         (clk),
			.nreset      (nreset),
			.signal_ok_i (signal_ok_i[g]),
			.valid_i     (valid_i),
			.chunk_i     (chunk_i[g*BLOCK_W +: BLOCK_W]),
			.valid_o     (lane_valid[g]),
			.data_o      (data_o[g*PAYLOAD_W +: PAYLOAD_W]),
			.ctrl_o      (ctrl_o[g]),
			.err_o       (err_o[g]),
			.lock_o      (lane_lock_o[g])
		);
	end

	assign valid_o    = lane_valid[0]; // shared strobe, lane 0 stands for all
	assign all_lock_o = &lane_lock_o;

	// pipelines must stay in step across lanes
	a_lanes_in_step: assert property (
		@(posedge clk) disable iff (nreset)
		(&lane_valid) || !(|lane_valid)
	) else $error("lane valid strobes diverged");

endmodule

`default_nettype wire

// File: source/pcs_rx_lane.sv
`default_nettype none

// one lane: gearbox, block lock, descrambler, decoder
module pcs_rx_lane (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             signal_ok_i,
	input  logic                             valid_i,
	input  logic [pcs_rx_pkg::BLOCK_W-1:0]   chunk_i,   // raw serdes bits
	output logic                             valid_o,
	output logic [pcs_rx_pkg::PAYLOAD_W-1:0] data_o,
	output logic                             ctrl_o,
	output logic                             err_o,
	output logic                             lock_o
);
	import pcs_rx_pkg::*;

	logic                 blk_v;       // aligned block strobe
	logic [HEAD_W-1:0]    blk_head;
	logic [PAYLOAD_W-1:0] blk_payload; // scrambled
	logic                 slip;        // lock fsm back to gearbox
	logic                 dsc_v;
	logic [HEAD_W-1:0]    dsc_head;
	payload_u             dsc_payload; // plain word

	gearbox_rx i_gearbox_rx (
		.clk       (clk),
		.nreset    (nreset),
		.valid_i   (valid_i),
		.chunk_i   (chunk_i),
		.slip_i    (slip),
		.valid_o   (blk_v),
		.head_o    (blk_head),
		.payload_o (blk_payload)
	);

	// same cycle as blk_v, closes the slip loop
	block_sync_rx i_block_sync_rx (
		.clk        (clk),
		.nreset     (nreset),
		.signal_v_i (signal_ok_i),
		.valid_i    (blk_v),
		.head_i     (blk_head),
		.slip_v_o   (slip),
		.lock_v_o   (lock_o)
	);

	descrambler_rx i_descrambler_rx (
		.clk       (clk),
		.nreset    (nreset),
		.valid_i   (blk_v),
		.payload_i (blk_payload),
		.head_i    (blk_head),
		.valid_o   (dsc_v),
		.head_o    (dsc_head),
		.payload_o (dsc_payload)
	);

	block_decode_rx i_block_decode_rx (
		.clk       (clk),
		.nreset    (nreset),
		.valid_i   (dsc_v),
		.head_i    (dsc_head),
		.payload_i (dsc_payload),
		.valid_o   (valid_o),
		.data_o    (data_o),
		.ctrl_o    (ctrl_o),
		.err_o     (err_o)
	);

endmodule

`default_nettype wire

// File: source/block_decode_rx.sv
`default_nettype none

// data or control split, header and type byte checks
module block_decode_rx (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             valid_i,
	input  logic [pcs_rx_pkg::HEAD_W-1:0]    head_i,
	input  pcs_rx_pkg::payload_u             payload_i,
	output logic                             valid_o,
	output logic [pcs_rx_pkg::PAYLOAD_W-1:0] data_o,
	output logic                             ctrl_o,
	output logic                             err_o
);
	import pcs_rx_pkg::*;

	logic is_ctrl;  // header says control
	logic head_bad; // 00 or 11
	logic bt_ok;    // type byte is a known one

	assign is_ctrl  = (head_i == SH_CTRL);
	assign head_bad = ~(head_i[0] ^ head_i[1]);

	// type byte through the control view
	always_comb begin
		case (payload_i.ctrl.btype)
			BT_1E, BT_2D, BT_33, BT_4B, BT_55,
			BT_66, BT_78, BT_87, BT_99, BT_AA,
			BT_B4, BT_CC, BT_D2, BT_E1, BT_FF: bt_ok = 1'b1;
			default:                           bt_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (nreset) begin
			valid_o <= 1'b0;
			ctrl_o  <= 1'b0;
			err_o   <= 1'b0;
		end else begin
			valid_o <= valid_i;
			if (valid_i) begin
				ctrl_o <= is_ctrl;
				err_o  <= head_bad | (is_ctrl & ~bt_ok); // type only matters on control
			end
		end
	end

	// payload goes out as bytes, even on error
	always_ff @(posedge clk) begin
		if (valid_i)
			data_o <= payload_i.data;
	end

endmodule

`default_nettype wire

// File: source/descrambler_rx.sv
`default_nettype none

// self-synchronous descrambler, x^58 + x^39 + 1
module descrambler_rx (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             valid_i,
	input  logic [pcs_rx_pkg::PAYLOAD_W-1:0] payload_i, // scrambled
	input  logic [pcs_rx_pkg::HEAD_W-1:0]    head_i,
	output logic                             valid_o,
	output logic [pcs_rx_pkg::HEAD_W-1:0]    head_o,
	output logic [pcs_rx_pkg::PAYLOAD_W-1:0] payload_o  // plain
);
	import pcs_rx_pkg::*;

	localparam int SCR_W = 58; // history length
	localparam int TAP   = 39; // inner tap

	logic [SCR_W-1:0]           hist_q; // last 58 scrambled bits, msb newest
	logic [PAYLOAD_W+SCR_W-1:0] ext;    // history then current word
	logic [PAYLOAD_W-1:0]       plain;

	assign ext = {payload_i, hist_q};

	// out[i] = in[i] ^ in[i-39] ^ in[i-58], whole word at once
	assign plain = payload_i
	             ^ ext[PAYLOAD_W+SCR_W-TAP-1:SCR_W-TAP]
	             ^ ext[PAYLOAD_W-1:0];

	always_ff @(posedge clk) begin
		if (nreset)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	// data path and history, hold on gaps
	always_ff @(posedge clk) begin
		if (valid_i) begin
			hist_q    <= ext[PAYLOAD_W+SCR_W-1:PAYLOAD_W]; // newest 58 bits
			head_o    <= head_i; // header is never scrambled
			payload_o <= plain;
		end
	end

endmodule

`default_nettype wire

// File: source/block_sync_rx.sv
`default_nettype none

// block lock per lane, 802.3 figure 49-14
// states are one-hot: invalid, syncing, locked
module block_sync_rx (
	input  logic                           clk,
	input  logic                           nreset,
	input  logic                           signal_v_i, // signal_ok from serdes
	input  logic                           valid_i,    // block strobe from gearbox
	input  logic [pcs_rx_pkg::HEAD_W-1:0]  head_i,
	output logic                           slip_v_o,   // one cycle, back to gearbox
	output logic                           lock_v_o    // rx_block_lock
);
	localparam int CNT_N    = 1024; // sh_cnt window
	localparam int CNT_W    = $clog2(CNT_N);
	localparam int GOOD_N   = 64;   // good headers to lock
	localparam int NV_CNT_N = 65;   // bad headers to lose lock
	localparam int NV_CNT_W = $clog2(NV_CNT_N);

	logic invalid_q; // no signal or just out of reset
	logic sync_q;    // hunting, not yet locked
	logic lock_q;    // locked

	logic                sh_v;       // header is 01 or 10
	logic [CNT_W-1:0]    cnt_q;      // sh_cnt
	logic [CNT_W-1:0]    cnt_add;
	logic                cnt_ovf;    // 1024 headers seen
	logic [NV_CNT_W-1:0] nv_cnt_q;   // sh_invalid_cnt
	logic [NV_CNT_W-1:0] nv_cnt_add;
	logic                good_64;    // 64_GOOD
	logic                bad_65;     // too many bad in window
	logic                slip_v;     // SLIP
	logic                cnt_rst;    // RESET_CNT

	// valid header has exactly one bit set
	assign sh_v = head_i[0] ^ head_i[1];

	// while syncing only good ones count, when locked every header counts
	assign {cnt_ovf, cnt_add} = {1'b0, cnt_q} + {{CNT_W{1'b0}}, sh_v | lock_q};
	assign nv_cnt_add         = nv_cnt_q + {{(NV_CNT_W-1){1'b0}}, ~sh_v};

	assign good_64 = sync_q & (cnt_add == CNT_W'(GOOD_N));
	assign bad_65  = lock_q & (nv_cnt_add == NV_CNT_W'(NV_CNT_N));

	// any miss while hunting, or window overrun while locked
	assign slip_v  = (sync_q & ~sh_v) | bad_65;

	// counters restart on every decision and at window end
	assign cnt_rst = invalid_q | good_64 | slip_v | cnt_ovf;

	always_ff @(posedge clk) begin
		if (nreset) begin
			invalid_q <= 1'b1;
			sync_q    <= 1'b0;
			lock_q    <= 1'b0;
			cnt_q     <= '0;
			nv_cnt_q  <= '0;
		end else if (valid_i) begin
			// signal loss wins from any state
			invalid_q <= ~signal_v_i;
			sync_q    <= signal_v_i & (invalid_q       // signal back, start hunting
			                         | (sync_q & ~good_64) // keep hunting
			                         | bad_65);            // lock lost
			lock_q    <= signal_v_i & ((lock_q & ~slip_v) | good_64);
			cnt_q     <= cnt_rst ? '0 : cnt_add;
			nv_cnt_q  <= cnt_rst ? '0 : nv_cnt_add;
		end
	end

	assign lock_v_o = lock_q;
	assign slip_v_o = valid_i & slip_v; // never without a block

	// exactly one state at all times
	a_fsm_onehot: assert property (
		@(posedge clk) disable iff (nreset)
		$onehot({invalid_q, sync_q, lock_q})
	) else $error("block sync state not one-hot");

	// a slip never leaves the lane locked
	a_slip_unlock: assert property (
		@(posedge clk) disable iff (nreset)
		slip_v_o |=> !lock_q
	) else $error("lane still locked after a slip");

endmodule

`default_nettype wire

// File: source/gearbox_rx.sv
`default_nettype none

module gearbox_rx (
	input  logic                            clk,
	input  logic                            nreset,
	input  logic                            valid_i,
	input  logic [pcs_rx_pkg::BLOCK_W-1:0]  chunk_i,
	input  logic                            slip_i,
	output logic                            valid_o,
	output logic [pcs_rx_pkg::HEAD_W-1:0]   head_o,
	output logic [pcs_rx_pkg::PAYLOAD_W-1:0] payload_o
);
	import pcs_rx_pkg::*;

	localparam int OFF_W   = 7;
	localparam int OFF_MAX = BLOCK_W - 1; // 65, wraps to 0

	logic [BLOCK_W-1:0]   prev_q;  // chunk from the last accepted beat
	logic [OFF_W-1:0]     off_q;   // bit offset of block start in the pair
	logic [2*BLOCK_W-1:0] pair;    // older chunk in the low half
	logic [2*BLOCK_W-1:0] shifted;

	// 132 bit window, earlier bits sit low
	assign pair    = {chunk_i, prev_q};
	assign shifted = pair >> off_q; // barrel shift down to block start

	// control state
	always_ff @(posedge clk) begin
		if (nreset) begin
			valid_o <= 1'b0;
			off_q   <= '0;
		end else begin
			valid_o <= valid_i;
			// one bit further per slip pulse
			if (slip_i) begin
				if (off_q == OFF_W'(OFF_MAX))
					off_q <= '0;
				else
					off_q <= off_q + 1'b1;
			end
		end
	end

	// payload path, frozen on gaps
	always_ff @(posedge clk) begin
		if (valid_i) begin
			prev_q    <= chunk_i;
			head_o    <= shifted[HEAD_W-1:0];       // sync header
			payload_o <= shifted[BLOCK_W-1:HEAD_W]; // still scrambled
		end
	end

	// wrap logic keeps the offset inside one block
	a_off_range: assert property (
		@(posedge clk) disable iff (nreset)
		slip_i |=> off_q <= OFF_W'(OFF_MAX)
	) else $error("gearbox offset out of range");

endmodule

`default_nettype wire

// File: source/pcs_rx_pkg.sv
`default_nettype none

package pcs_rx_pkg;

	// block geometry, bit 0 is the first bit on the wire
	localparam int HEAD_W    = 2;
	localparam int PAYLOAD_W = 64;
	localparam int BLOCK_W   = HEAD_W + PAYLOAD_W;

	// sync header codes
	localparam logic [HEAD_W-1:0] SH_DATA = 2'b01; // all eight bytes are data
	localparam logic [HEAD_W-1:0] SH_CTRL = 2'b10; // first byte is a block type

	// legal control block type bytes, clause 49 table
	localparam logic [7:0] BT_1E = 8'h1e; // all control
	localparam logic [7:0] BT_2D = 8'h2d;
	localparam logic [7:0] BT_33 = 8'h33;
	localparam logic [7:0] BT_4B = 8'h4b; // ordered set in lane 0
	localparam logic [7:0] BT_55 = 8'h55;
	localparam logic [7:0] BT_66 = 8'h66;
	localparam logic [7:0] BT_78 = 8'h78; // start in lane 0
	localparam logic [7:0] BT_87 = 8'h87; // terminate variants from here
	localparam logic [7:0] BT_99 = 8'h99;
	localparam logic [7:0] BT_AA = 8'haa;
	localparam logic [7:0] BT_B4 = 8'hb4;
	localparam logic [7:0] BT_CC = 8'hcc;
	localparam logic [7:0] BT_D2 = 8'hd2;
	localparam logic [7:0] BT_E1 = 8'he1;
	localparam logic [7:0] BT_FF = 8'hff; // terminate in lane 7

	// one payload word, read either as bytes or as type byte plus body
	typedef union packed {
		logic [7:0][7:0] data; // data[0] goes out first
		struct packed {
			logic [55:0] body;  // control characters and ordered set bits
			logic [7:0]  btype; // low byte, first on the wire
		} ctrl;
	} payload_u;

endpackage

`default_nettype wire
